// File: majority_cfg.svh
`ifndef MAJORITY_CFG_SVH
`define MAJORITY_CFG_SVH

// votes carried by one data word
// tied to the selector count in each lane counter
`define WORD_W 32

// output dimensions bundled side by side
`define LANES 4

// signed accumulator width per lane
// MAX_ITEMS votes plus the tie offset need far fewer bits
`define ACC_W 30

// largest group of hypervectors in one run
`define MAX_ITEMS 1000

`endif

// File: hv_pkg.sv
`include "majority_cfg.svh"

package hv_pkg;

    // one lane's word, bit k is input vector k of the batch
    typedef logic [`WORD_W-1:0] word_t;

    // one majority bit per output dimension
    typedef logic [`LANES-1:0] lane_bits_t;

    // lane l sits at index l
    typedef word_t [`LANES-1:0] lane_words_t;

    // number of hypervectors in a run, zero is not a legal value
    typedef logic [$clog2(`MAX_ITEMS + 1)-1:0] item_count_t;

    // valid bits in the final word
    // zero means the final word is full
    typedef logic [$clog2(`WORD_W)-1:0] remainder_t;

endpackage

// File: vote_pkg.sv
`include "majority_cfg.svh"

package vote_pkg;

    // one vote, -1, 0 or +1
    typedef logic signed [1:0] vote_t;

    localparam vote_t VOTE_POS  = 2'sb01;
    localparam vote_t VOTE_NEG  = 2'sb11;
    localparam vote_t VOTE_ZERO = 2'sb00;

    // sum of four votes, range -4 to +4
    typedef logic signed [3:0] quad_sum_t;

    // sum of sixteen votes, range -16 to +16
    typedef logic signed [6:0] half_sum_t;

    // running sum over the whole run
    typedef logic signed [`ACC_W-1:0] acc_t;

endpackage

// File: vote_selector.sv
`timescale 1ns/1ps

module vote_selector #(
    parameter int INDEX = 0
) (
    input  logic               clk,
    input  logic               update,
    input  logic               last_update,
    input  hv_pkg::remainder_t remainder,
    input  logic               data_bit,
    output vote_pkg::vote_t    vote
);

    localparam int POSITIONS = 2 ** $bits(hv_pkg::remainder_t);

    logic masked;

    if (INDEX < 0 || INDEX >= POSITIONS) begin : g_bad_index
        $error("vote_selector INDEX %0d out of range", INDEX);
    end

    // bits at or above the remainder lie past the final item
    // remainder zero keeps the whole word
    assign masked = last_update && (remainder != '0) && (INDEX >= int'(remainder));

    // vote stays zero between words so the tree can run freely
    always_ff @(posedge clk) begin
        if (!update || masked) begin
            vote <= vote_pkg::VOTE_ZERO;
        end else if (data_bit) begin
            vote <= vote_pkg::VOTE_POS;
        end else begin
            vote <= vote_pkg::VOTE_NEG;
        end
    end

endmodule

// File: vote_counter.sv
`timescale 1ns/1ps
`include "majority_cfg.svh"

module vote_counter (
    input  logic               clk,
    input  logic               clear,
    input  logic               even_votes,
    input  logic               tie_bit,
    input  logic               update,
    input  logic               last_update,
    input  hv_pkg::remainder_t remainder,
    input  hv_pkg::word_t      word,
    output logic               majority
);

    localparam int QUADS = `WORD_W / 4;
    localparam int HALVES = QUADS / 4;

    localparam vote_pkg::acc_t ACC_ONE = 1;
    localparam vote_pkg::acc_t ACC_MAX = `MAX_ITEMS + 1;

    vote_pkg::vote_t     votes [`WORD_W];
    vote_pkg::quad_sum_t quad  [QUADS];
    vote_pkg::half_sum_t half  [HALVES];
    vote_pkg::acc_t      acc;

    // update delayed to each tree stage
    logic upd1;
    logic upd2;
    logic upd3;

    for (genvar i = 0; i < `WORD_W; i++) begin : g_sel
        vote_selector #(
            .INDEX(i)
        ) i_sel (
            .clk        (clk),
            .update     (update),
            .last_update(last_update),
            .remainder  (remainder),
            .data_bit   (word[i]),
            .vote       (votes[i])
        );
    end

    always_ff @(posedge clk) begin
        upd1 <= update;
        upd2 <= upd1;
        upd3 <= upd2;
    end

    // stage one, groups of four votes
    always_ff @(posedge clk) begin
        if (upd1) begin
            for (int q = 0; q < QUADS; q++) begin
                quad[q] <= votes[4*q] + votes[4*q+1] + votes[4*q+2] + votes[4*q+3];
            end
        end
    end

    // stage two, one sum per half word
    always_ff @(posedge clk) begin
        if (upd2) begin
            for (int h = 0; h < HALVES; h++) begin
                half[h] <= quad[4*h] + quad[4*h+1] + quad[4*h+2] + quad[4*h+3];
            end
        end
    end

    // even groups start one off zero so the final sum is never zero
    always_ff @(posedge clk) begin
        if (clear) begin
            if (even_votes) begin
                acc <= tie_bit ? -ACC_ONE : ACC_ONE;
            end else begin
                acc <= '0;
            end
        end else if (upd3) begin
            acc <= acc + half[0] + half[1];
        end
    end

    // positive sum means more ones than zeros
    assign majority = ~acc[`ACC_W-1];

    // a new run must not begin while a word is still in the tree
    a_clear_idle: assert property (@(posedge clk)
        clear |-> ((upd1 | upd2 | upd3) !== 1'b1));

    a_acc_range: assert property (@(posedge clk)
        upd3 |=> (acc <= ACC_MAX) && (acc >= -ACC_MAX));

endmodule

// File: bundle_ctrl.sv
`timescale 1ns/1ps

module bundle_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  hv_pkg::item_count_t item_count,
    input  logic                tie_break,
    input  logic                word_valid,
    output logic                busy,
    output logic                done,
    output logic                clear,
    output logic                even_votes,
    output logic                tie_bit,
    output logic                update,
    output logic                last_update,
    output hv_pkg::remainder_t  remainder
);

    localparam int REM_W = $bits(hv_pkg::remainder_t);
    localparam int IDX_W = $bits(hv_pkg::item_count_t) - REM_W;

    logic             start_ok;
    logic             collecting;
    logic [IDX_W-1:0] word_cnt;
    logic [IDX_W-1:0] last_idx;
    logic [3:0]       done_sr;

    hv_pkg::remainder_t rem_q;

    assign start_ok = start && !busy;

    // words count only while the run still expects data
    assign update      = word_valid && collecting;
    assign last_update = update && (word_cnt == last_idx);
    assign remainder   = rem_q;

    // done trails the last word by the four register stages of a lane
    assign done = done_sr[3];

    // index of the final word is (item_count - 1) / 32
    always_ff @(posedge clk) begin
        if (start_ok) begin
            last_idx <= IDX_W'((item_count - 1'b1) >> REM_W);
            rem_q    <= item_count[REM_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            collecting <= 1'b0;
            word_cnt   <= '0;
            done_sr    <= '0;
            // park the lanes at minus one so majority reads zero
            clear      <= 1'b1;
            even_votes <= 1'b1;
            tie_bit    <= 1'b1;
        end else begin
            clear   <= start_ok;
            done_sr <= {done_sr[2:0], last_update};
            if (start_ok) begin
                busy       <= 1'b1;
                collecting <= 1'b1;
                word_cnt   <= '0;
                even_votes <= ~item_count[0];
                tie_bit    <= tie_break;
            end else begin
                if (update) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (last_update) begin
                    collecting <= 1'b0;
                end
                // busy drops together with the done pulse
                if (done_sr[2]) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

    // an accepted start finds the previous run fully drained
    a_start_ignored: assert property (@(posedge clk) disable iff (rst)
        start_ok |-> (!collecting && (done_sr[2:0] == '0)));

    a_count_nonzero: assert property (@(posedge clk) disable iff (rst)
        start_ok |-> (item_count != '0));

endmodule

// File: majority_bundler.sv
`timescale 1ns/1ps
`include "majority_cfg.svh"

module majority_bundler (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  hv_pkg::item_count_t item_count,
    input  logic                tie_break,
    input  logic                word_valid,
    input  hv_pkg::lane_words_t words,
    output logic                busy,
    output logic                done,
    output hv_pkg::lane_bits_t  majority
);

    // controller to lane counters
    logic clear;
    logic even_votes;
    logic tie_bit;
    logic update;
    logic last_update;

    hv_pkg::remainder_t remainder;

    bundle_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .item_count (item_count),
        .tie_break  (tie_break),
        .word_valid (word_valid),
        .busy       (busy),
        .done       (done),
        .clear      (clear),
        .even_votes (even_votes),
        .tie_bit    (tie_bit),
        .update     (update),
        .last_update(last_update),
        .remainder  (remainder)
    );

    // one counter per output dimension, all sharing the same strobes
    for (genvar l = 0; l < `LANES; l++) begin : g_lane
        vote_counter i_counter (
            .clk        (clk),
            .clear      (clear),
            .even_votes (even_votes),
            .tie_bit    (tie_bit),
            .update     (update),
            .last_update(last_update),
            .remainder  (remainder),
            .word       (words[l]),
            .majority   (majority[l])
        );
    end

endmodule

// File: tb_majority_bundler.sv
`timescale 1ns/1ps
`include "majority_cfg.svh"

module tb_majority_bundler;

    localparam int NUM_CASES = 12;
    localparam int MAX_WORDS = (`MAX_ITEMS + `WORD_W - 1) / `WORD_W;
    localparam int DONE_LATENCY = 4;

    typedef struct packed {
        hv_pkg::item_count_t count;
        logic                tie;
        logic                back_to_back;
        logic                balanced;
        logic                reuse;
    } case_t;

    // count, tie_break, back-to-back, balanced pattern, reuse previous words
    localparam case_t CASES [NUM_CASES] = '{
        '{1,    1'b0, 1'b1, 1'b0, 1'b0},
        '{31,   1'b0, 1'b0, 1'b0, 1'b0},
        '{33,   1'b1, 1'b1, 1'b0, 1'b0},
        '{999,  1'b0, 1'b1, 1'b0, 1'b0},
        '{999,  1'b1, 1'b0, 1'b0, 1'b1},
        '{32,   1'b0, 1'b1, 1'b0, 1'b0},
        '{64,   1'b0, 1'b1, 1'b1, 1'b0},
        '{64,   1'b1, 1'b0, 1'b1, 1'b0},
        '{40,   1'b0, 1'b0, 1'b1, 1'b0},
        '{2,    1'b1, 1'b1, 1'b1, 1'b0},
        '{1000, 1'b0, 1'b0, 1'b1, 1'b0},
        '{1000, 1'b1, 1'b1, 1'b0, 1'b0}
    };

    logic                clk;
    logic                rst;
    logic                start;
    hv_pkg::item_count_t item_count;
    logic                tie_break;
    logic                word_valid;
    hv_pkg::lane_words_t words;
    logic                busy;
    logic                done;
    hv_pkg::lane_bits_t  majority;

    hv_pkg::lane_words_t batch [MAX_WORDS];
    integer              seed = 91293;
    int                  cycles = 0;
    int                  cycle_limit = 0;

    majority_bundler i_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .item_count (item_count),
        .tie_break  (tie_break),
        .word_valid (word_valid),
        .words      (words),
        .busy       (busy),
        .done       (done),
        .majority   (majority)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bits(string name, hv_pkg::lane_bits_t got, hv_pkg::lane_bits_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic random_words(output hv_pkg::lane_words_t lw);
        for (int l = 0; l < `LANES; l++) begin
            lw[l] = $random(seed);
        end
    endtask

    task automatic fill_batch(int nwords, logic balanced);
        hv_pkg::lane_words_t tmp;
        for (int w = 0; w < nwords; w++) begin
            random_words(tmp);
            if (balanced) begin
                // alternating bits, equal ones and zeros over any even prefix
                tmp = {(`LANES * `WORD_W / 2){2'b01}};
            end
            batch[w] = tmp;
        end
    endtask

    // plus one per 1 bit, minus one per 0 bit, offset breaks even ties
    function automatic hv_pkg::lane_bits_t expected_majority(int count, logic tie);
        int                 sum;
        hv_pkg::lane_bits_t res;
        for (int l = 0; l < `LANES; l++) begin
            sum = 0;
            if (count % 2 == 0) begin
                sum = tie ? -1 : 1;
            end
            for (int i = 0; i < count; i++) begin
                sum += batch[i / `WORD_W][l][i % `WORD_W] ? 1 : -1;
            end
            res[l] = (sum > 0);
        end
        return res;
    endfunction

    task automatic run_case(int idx);
        case_t               c;
        int                  nwords;
        int                  k;
        hv_pkg::lane_bits_t  exp;
        hv_pkg::lane_words_t junk;
        c = CASES[idx];
        nwords = (int'(c.count) + `WORD_W - 1) / `WORD_W;
        if (!c.reuse) begin
            fill_batch(nwords, c.balanced);
        end
        exp = c.balanced ? {`LANES{~c.tie}} : expected_majority(c.count, c.tie);

        // stray words while idle
        for (int j = 0; j < 2; j++) begin
            @(posedge clk);
            random_words(junk);
            word_valid <= 1'b1;
            words      <= junk;
        end
        @(posedge clk);
        word_valid <= 1'b0;
        start      <= 1'b1;
        item_count <= c.count;
        tie_break  <= c.tie;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);

        for (int w = 0; w < nwords; w++) begin
            @(posedge clk);
            start      <= 1'b0;
            word_valid <= 1'b1;
            words      <= batch[w];
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
            check_flag("done", done, 1'b0);
            if (!c.back_to_back && w < nwords - 1) begin
                @(posedge clk);
                word_valid <= 1'b0;
                words      <= '0;
            end
        end

        // extra words and a second start before done
        k = 0;
        do begin
            @(posedge clk);
            k++;
            if (k <= 2) begin
                random_words(junk);
                word_valid <= 1'b1;
                words      <= junk;
            end else begin
                word_valid <= 1'b0;
            end
            start <= (k == 2);
            if (k == 2) begin
                item_count <= 7;
                tie_break  <= ~c.tie;
            end
            @(negedge clk);
            if (done !== 1'b1) begin
                check_flag("busy", busy, 1'b1);
            end
            if (k > DONE_LATENCY + 4) begin
                $display("done never arrived after the last word of case %0d", idx);
                abort_run();
            end
        end while (done !== 1'b1);

        if (k != DONE_LATENCY) begin
            $display("** Error: done latency = 0x%h, expected 0x%h", k, DONE_LATENCY);
            abort_run();
        end
        check_flag("busy", busy, 1'b0);
        check_bits("majority", majority, exp);

        // result holds after the pulse
        @(posedge clk);
        start      <= 1'b0;
        word_valid <= 1'b0;
        @(negedge clk);
        check_flag("done", done, 1'b0);
        check_bits("majority", majority, exp);
    endtask

    initial begin
        int total_words;
        rst        = 1'b1;
        start      = 1'b0;
        item_count = '0;
        tie_break  = 1'b0;
        word_valid = 1'b0;
        words      = '0;

        total_words = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            total_words += (int'(CASES[i].count) + `WORD_W - 1) / `WORD_W;
        end
        // gaps double the words, plus per-case overhead, then a margin of two
        cycle_limit = 2 * (2 * total_words + 16 * NUM_CASES) + 20;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_bits("majority", majority, '0);

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: majority_bundler.f
+incdir+.
hv_pkg.sv
vote_pkg.sv
vote_selector.sv
vote_counter.sv
bundle_ctrl.sv
majority_bundler.sv
tb_majority_bundler.sv

// File: Bender.yml
package:
  name: majority_bundler

sources:
  - include_dirs:
      - .
    files:
      - hv_pkg.sv
      - vote_pkg.sv
      - vote_selector.sv
      - vote_counter.sv
      - bundle_ctrl.sv
      - majority_bundler.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_majority_bundler.sv
